/* bench/dsp_misc_ref.svh */
`ifndef DSP_MISC_REF_SVH
`define DSP_MISC_REF_SVH

// lanes of width w limited to [-2^n, 2^n-1], or [0, 2^n-1] when unsigned.
function automatic logic [XLEN:0] clip_lanes(logic [XLEN-1:0] val, int w, int n, bit sgn);
	logic [XLEN-1:0] mask;
	logic [XLEN-1:0] word;
	logic ov;
	longint v;
	longint top;
	longint bot;
	mask = XLEN'((longint'(1) << w) - 1);
	word = '0;
	ov = 1'b0;
	top = (longint'(1) << n) - 1;
	bot = sgn ? -(longint'(1) << n) : 0;
	for (int l = 0; l < XLEN / w; l++) begin
		v = longint'((val >> (l * w)) & mask);
		if (v >= (longint'(1) << (w - 1))) begin
			v = v - (longint'(1) << w); // back to signed.
		end
		if (v > top || v < bot) begin
			ov = 1'b1;
			v = (v > top) ? top : bot;
		end
		word = word | ((XLEN'(v) & mask) << (l * w));
	end
	return {ov, word};
endfunction

// redundant counts copies of the sign below the msb.
function automatic logic [XLEN-1:0] count_lanes(logic [XLEN-1:0] val, int w, bit redundant,
		bit ones);
	logic [XLEN-1:0] word;
	logic cmp;
	bit run;
	int c;
	word = '0;
	for (int l = 0; l < XLEN / w; l++) begin
		cmp = redundant ? val[l*w+w-1] : ones;
		run = 1'b1;
		c = 0;
		for (int i = (redundant ? w - 2 : w - 1); i >= 0; i--) begin
			if (run && val[l*w+i] == cmp) begin
				c++;
			end else begin
				run = 1'b0;
			end
		end
		word = word | (XLEN'(c) << (l * w));
	end
	return word;
endfunction

function automatic logic [HALF_W-1:0] widen_byte(logic [XLEN-1:0] val, int b, bit sgn);
	logic [BYTE_W-1:0] v;
	v = val[b*BYTE_W +: BYTE_W];
	return {{BYTE_W{sgn & v[BYTE_W-1]}}, v};
endfunction

function automatic logic [HALF_W-1:0] half_of(logic [XLEN-1:0] val, bit upper);
	return val[upper*HALF_W +: HALF_W];
endfunction

// result byte b is source byte b ^ flip.
function automatic logic [XLEN-1:0] move_bytes(logic [XLEN-1:0] val, int flip);
	logic [XLEN-1:0] word;
	for (int b = 0; b < BYTES_PER_WORD; b++) begin
		word[b*BYTE_W +: BYTE_W] = val[(b ^ flip)*BYTE_W +: BYTE_W];
	end
	return word;
endfunction

function automatic logic [XLEN-1:0] pick_bits(logic [XLEN-1:0] sel, logic [XLEN-1:0] a,
		logic [XLEN-1:0] b);
	logic [XLEN-1:0] word;
	for (int i = 0; i < XLEN; i++) begin
		word[i] = sel[i] ? a[i] : b[i];
	end
	return word;
endfunction

// expected {ov, word} for one decoded operation.
function automatic logic [XLEN:0] ref_dsp(logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2,
		logic [XLEN-1:0] rc, logic [XLEN-1:0] rd, logic [INFO_W-1:0] info);
	logic [IMM_W-1:0] imm;
	logic [XLEN-1:0] word;
	logic [XLEN:0] res;
	imm = info[INFO_IMM_LSB +: IMM_W];
	case (1'b1)
		info[INFO_SCLIP8]: res = clip_lanes(rs1, BYTE_W, int'(imm[2:0]), 1'b1);
		info[INFO_UCLIP8]: res = clip_lanes(rs1, BYTE_W, int'(imm[2:0]), 1'b0);
		info[INFO_SCLIP16]: res = clip_lanes(rs1, HALF_W, int'(imm[3:0]), 1'b1);
		info[INFO_UCLIP16]: res = clip_lanes(rs1, HALF_W, int'(imm[3:0]), 1'b0);
		info[INFO_SCLIP32]: res = clip_lanes(rs1, XLEN, int'(imm), 1'b1);
		info[INFO_UCLIP32]: res = clip_lanes(rs1, XLEN, int'(imm), 1'b0);
		info[INFO_SUNPKD810]: res = {1'b0, widen_byte(rs1, 1, 1'b1), widen_byte(rs1, 0, 1'b1)};
		info[INFO_SUNPKD820]: res = {1'b0, widen_byte(rs1, 2, 1'b1), widen_byte(rs1, 0, 1'b1)};
		info[INFO_SUNPKD830]: res = {1'b0, widen_byte(rs1, 3, 1'b1), widen_byte(rs1, 0, 1'b1)};
		info[INFO_SUNPKD831]: res = {1'b0, widen_byte(rs1, 3, 1'b1), widen_byte(rs1, 1, 1'b1)};
		info[INFO_SUNPKD832]: res = {1'b0, widen_byte(rs1, 3, 1'b1), widen_byte(rs1, 2, 1'b1)};
		info[INFO_ZUNPKD810]: res = {1'b0, widen_byte(rs1, 1, 1'b0), widen_byte(rs1, 0, 1'b0)};
		info[INFO_ZUNPKD820]: res = {1'b0, widen_byte(rs1, 2, 1'b0), widen_byte(rs1, 0, 1'b0)};
		info[INFO_ZUNPKD830]: res = {1'b0, widen_byte(rs1, 3, 1'b0), widen_byte(rs1, 0, 1'b0)};
		info[INFO_ZUNPKD831]: res = {1'b0, widen_byte(rs1, 3, 1'b0), widen_byte(rs1, 1, 1'b0)};
		info[INFO_ZUNPKD832]: res = {1'b0, widen_byte(rs1, 3, 1'b0), widen_byte(rs1, 2, 1'b0)};
		info[INFO_PKBB16]: res = {1'b0, half_of(rs1, 1'b0), half_of(rs2, 1'b0)};
		info[INFO_PKBT16]: res = {1'b0, half_of(rs1, 1'b0), half_of(rs2, 1'b1)};
		info[INFO_PKTB16]: res = {1'b0, half_of(rs1, 1'b1), half_of(rs2, 1'b0)};
		info[INFO_PKTT16]: res = {1'b0, half_of(rs1, 1'b1), half_of(rs2, 1'b1)};
		info[INFO_CLRS8]: res = {1'b0, count_lanes(rs1, BYTE_W, 1'b1, 1'b0)};
		info[INFO_CLZ8]: res = {1'b0, count_lanes(rs1, BYTE_W, 1'b0, 1'b0)};
		info[INFO_CLO8]: res = {1'b0, count_lanes(rs1, BYTE_W, 1'b0, 1'b1)};
		info[INFO_CLRS16]: res = {1'b0, count_lanes(rs1, HALF_W, 1'b1, 1'b0)};
		info[INFO_CLZ16]: res = {1'b0, count_lanes(rs1, HALF_W, 1'b0, 1'b0)};
		info[INFO_CLO16]: res = {1'b0, count_lanes(rs1, HALF_W, 1'b0, 1'b1)};
		info[INFO_CLRS32]: res = {1'b0, count_lanes(rs1, XLEN, 1'b1, 1'b0)};
		info[INFO_CLZ32]: res = {1'b0, count_lanes(rs1, XLEN, 1'b0, 1'b0)};
		info[INFO_CLO32]: res = {1'b0, count_lanes(rs1, XLEN, 1'b0, 1'b1)};
		info[INFO_BPICK]: res = {1'b0, pick_bits(rc, rs1, rs2)};
		info[INFO_INSB]: begin
			word = rd;
			word[imm[1:0]*BYTE_W +: BYTE_W] = rs1[BYTE_W-1:0];
			res = {1'b0, word};
		end
		info[INFO_SWAP8]: res = {1'b0, move_bytes(rs1, 1)};
		info[INFO_SWAP16]: res = {1'b0, move_bytes(rs1, 2)};
		default: res = '0;
	endcase
	return res;
endfunction

`endif

/* bench/dsp_misc_tb.sv */
`timescale 1ns/1ns

module dsp_misc_tb;
	import dsp_misc_pkg::*;

	`include "dsp_misc_ref.svh"

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int MARGIN_CYCLES = 10;
	localparam logic [31:0] SEED = 32'hfcf3bde9;
	localparam int N_IMM = 1 << IMM_W;
	localparam int N_CLIP_RAND = 4;
	localparam int N_EDGE = 4; // at top, above top, at bottom, below bottom.
	localparam int N_CNT_RAND = 24;
	localparam int N_PERM_RAND = 32;
	localparam int N_IDLE = 32;
	localparam int N_CLIP = 6 * N_IMM * (N_CLIP_RAND + N_EDGE);
	localparam int N_CNT = 9 * (N_CNT_RAND + 2 + XLEN);
	localparam int N_UNPK = 14 * N_PERM_RAND;
	localparam int N_MOVE = 7 * N_PERM_RAND; // swap8, swap16, bpick, insb at 4 bytes.
	localparam int N_TOTAL = N_CLIP + N_CNT + N_UNPK + N_MOVE + N_IDLE;

	logic clk;
	logic reset_i;
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic [XLEN-1:0] rc;
	logic [XLEN-1:0] rd;
	logic [INFO_W-1:0] info;
	logic [XLEN-1:0] wdat;
	logic ov;
	logic vec_valid;
	string test_name;
	string op_name;
	int test_vecs;
	int test_errs;
	int test_count;
	int vec_count;
	int err_count;

	// indexed by operation bit position.
	string op_names [OP_W] = '{"sclip8", "uclip8", "sclip16", "uclip16", "sclip32", "uclip32",
		"sunpkd810", "sunpkd820", "sunpkd830", "sunpkd831", "sunpkd832",
		"zunpkd810", "zunpkd820", "zunpkd830", "zunpkd831", "zunpkd832",
		"pkbb16", "pkbt16", "pktb16", "pktt16",
		"clrs8", "clz8", "clo8", "clrs16", "clz16", "clo16", "clrs32", "clz32", "clo32",
		"bpick", "insb", "swap8", "swap16"};

	dsp_misc_top uut (
		.clk     (clk),
		.reset_i (reset_i),
		.rs1_i   (rs1),
		.rs2_i   (rs2),
		.rc_i    (rc),
		.rd_i    (rd),
		.info_i  (info),
		.wdat_o  (wdat),
		.ov_o    (ov)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#((N_TOTAL + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("timeout: %s did not finish in the allowed time", test_name);
		$display("Test failed");
		$finish;
	end

	task automatic check_wdat(input logic [XLEN-1:0] exp, input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s %s wdat: expected %08h, actual %08h", test_name, op_name,
				exp, act);
			test_errs++;
			err_count++;
		end
	endtask

	task automatic check_ov(input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s %s ov: expected %0b, actual %0b", test_name, op_name, exp, act);
			test_errs++;
			err_count++;
		end
	endtask

	always @(posedge clk) begin
		logic [XLEN:0] expected;
		if (vec_valid) begin
			expected = ref_dsp(rs1, rs2, rc, rd, info);
			check_wdat(expected[XLEN-1:0], wdat);
			check_ov(expected[XLEN], ov);
			test_vecs++;
		end
	end

	// a negative position leaves every operation bit clear.
	task automatic apply(input int pos, input logic [IMM_W-1:0] imm, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [XLEN-1:0] c, input logic [XLEN-1:0] d);
		@(negedge clk);
		info = '0;
		if (pos >= 0) begin
			info[pos] = 1'b1;
		end
		info[INFO_IMM_LSB +: IMM_W] = imm;
		op_name = (pos >= 0) ? op_names[pos] : "none";
		rs1 = a;
		rs2 = b;
		rc = c;
		rd = d;
		vec_valid = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_vecs = 0;
		test_errs = 0;
	endtask

	task automatic end_test();
		@(negedge clk);
		vec_valid = 1'b0;
		$display("test %s: %0d vectors, %0d errors", test_name, test_vecs, test_errs);
		test_count++;
		vec_count += test_vecs;
	endtask

	// lanes cycle through the four values around the clip bounds.
	function automatic logic [XLEN-1:0] boundary_word(int w, int n, int sel);
		longint edge_val [4];
		logic [XLEN-1:0] word;
		edge_val[0] = (longint'(1) << n) - 1;
		edge_val[1] = longint'(1) << n;
		edge_val[2] = -(longint'(1) << n);
		edge_val[3] = -(longint'(1) << n) - 1;
		word = '0;
		for (int l = 0; l < XLEN / w; l++) begin
			word = word | ((XLEN'(edge_val[(sel + l) % 4]) & XLEN'((longint'(1) << w) - 1))
				<< (l * w));
		end
		return word;
	endfunction

	// long runs of leading zeros or ones.
	function automatic logic [XLEN-1:0] lead_word();
		logic [XLEN-1:0] word;
		word = $urandom >> ($urandom % XLEN);
		return ($urandom % 2) ? ~word : word;
	endfunction

	initial begin
		int w;
		void'($urandom(SEED));
		rs1 = '0;
		rs2 = '0;
		rc = '0;
		rd = '0;
		info = '0;
		vec_valid = 1'b0;
		test_name = "reset";
		op_name = "none";
		test_vecs = 0;
		test_errs = 0;
		test_count = 0;
		vec_count = 0;
		err_count = 0;
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset_i = 1'b0;

		start_test("clip");
		for (int k = 0; k < 6; k++) begin
			w = BYTE_W << (k / 2); // signed and unsigned form per lane width.
			for (int imm = 0; imm < N_IMM; imm++) begin
				for (int j = 0; j < N_CLIP_RAND; j++) begin
					apply(INFO_SCLIP8 + k, IMM_W'(imm), $urandom, $urandom, $urandom, $urandom);
				end
				for (int j = 0; j < N_EDGE; j++) begin
					apply(INFO_SCLIP8 + k, IMM_W'(imm), boundary_word(w, imm % w, j), $urandom,
						$urandom, $urandom);
				end
			end
		end
		end_test();

		start_test("lead_count");
		for (int op = INFO_CLRS8; op <= INFO_CLO32; op++) begin
			for (int j = 0; j < N_CNT_RAND; j++) begin
				apply(op, IMM_W'($urandom), lead_word(), $urandom, $urandom, $urandom);
			end
			apply(op, '0, '0, $urandom, $urandom, $urandom);
			apply(op, '0, '1, $urandom, $urandom, $urandom);
			for (int i = 0; i < XLEN; i++) begin
				apply(op, '0, (i % 2) ? ~(XLEN'(1) << i) : XLEN'(1) << i, $urandom, $urandom,
					$urandom);
			end
		end
		end_test();

		start_test("unpack_pack");
		for (int op = INFO_SUNPKD810; op <= INFO_PKTT16; op++) begin
			for (int j = 0; j < N_PERM_RAND; j++) begin
				apply(op, IMM_W'($urandom), $urandom, $urandom, $urandom, $urandom);
			end
		end
		end_test();

		start_test("swap_insb_bpick");
		for (int j = 0; j < N_PERM_RAND; j++) begin
			apply(INFO_SWAP8, IMM_W'($urandom), $urandom, $urandom, $urandom, $urandom);
			apply(INFO_SWAP16, IMM_W'($urandom), $urandom, $urandom, $urandom, $urandom);
			apply(INFO_BPICK, IMM_W'($urandom), $urandom, $urandom, $urandom, $urandom);
			for (int p = 0; p < BYTES_PER_WORD; p++) begin
				apply(INFO_INSB, IMM_W'(($urandom << 2) | p), $urandom, $urandom, $urandom,
					$urandom);
			end
		end
		end_test();

		start_test("idle");
		for (int j = 0; j < N_IDLE; j++) begin
			apply(-1, '0, $urandom, $urandom, $urandom, $urandom);
		end
		end_test();

		$display("summary: %0d tests, %0d vectors, %0d errors", test_count, vec_count, err_count);
		if (err_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* compile.f */
+incdir+bench
source/dsp_misc_pkg.sv
source/dsp_operand_if.sv
source/dsp_sat_detect.sv
source/dsp_clip_unit.sv
source/dsp_lead_count.sv
source/dsp_count_unit.sv
source/dsp_permute_unit.sv
source/dsp_misc_top.sv
bench/dsp_misc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dsp misc testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f compile.f --top-module dsp_misc_tb -o dsp_misc_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/dsp_misc_sim > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

/* source/dsp_clip_unit.sv */
`timescale 1ns/1ns

module dsp_clip_unit (
	input  logic                          clk,
	input  logic                          reset_i,
	dsp_operand_if.unit                   opnd,
	output logic [dsp_misc_pkg::XLEN-1:0] wdat_o,
	output logic                          ov_o
);
	import dsp_misc_pkg::*;

	logic sgn;
	logic clip8;
	logic clip16;
	logic clip32;
	logic [IMM_W-1:0] imm;
	logic [IMM_W-1:0] bound_exp;
	logic [XLEN-1:0] bound_top;
	logic [XLEN-1:0] bound_bot;
	logic [OV_W-1:0] t_ov;
	logic [OV_W-1:0] b_ov;
	logic [OV_W-1:0] neg;
	logic [OV_W-1:0] keep;
	logic [XLEN-1:0] res8;
	logic [XLEN-1:0] res16;
	logic [XLEN-1:0] res32;

	assign sgn = opnd.info[INFO_SCLIP8] | opnd.info[INFO_SCLIP16] | opnd.info[INFO_SCLIP32];
	assign clip8 = opnd.info[INFO_SCLIP8] | opnd.info[INFO_UCLIP8];
	assign clip16 = opnd.info[INFO_SCLIP16] | opnd.info[INFO_UCLIP16];
	assign clip32 = opnd.info[INFO_SCLIP32] | opnd.info[INFO_UCLIP32];
	assign imm = opnd.info[INFO_IMM_LSB +: IMM_W];

	always_comb begin
		bound_exp = imm;
		if (clip8) begin
			bound_exp = {2'b00, imm[2:0]};
		end else if (clip16) begin
			bound_exp = {1'b0, imm[3:0]};
		end
	end

	assign bound_top = (XLEN'(1) << bound_exp) - XLEN'(1); // 2^n-1.
	assign bound_bot = ~bound_top; // -2^n.

	dsp_sat_detect u_sat (
		.op_i        (opnd.rs1),
		.bound_top_i (bound_top),
		.bound_bot_i (bound_bot),
		.t_ov_o      (t_ov),
		.b_ov_o      (b_ov)
	);

	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			neg[b] = opnd.rs1[b*BYTE_W+BYTE_W-1];
		end
		for (int h = 0; h < HALVES_PER_WORD; h++) begin
			neg[OV_HALF_LSB+h] = opnd.rs1[h*HALF_W+HALF_W-1];
		end
		neg[OV_WORD_BIT] = opnd.rs1[XLEN-1];
	end

	// unsigned forms never keep a negative lane.
	assign keep = (neg & ~b_ov & {OV_W{sgn}}) | (~neg & ~t_ov);

	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			res8[b*BYTE_W +: BYTE_W] = keep[b] ? opnd.rs1[b*BYTE_W +: BYTE_W] :
				!neg[b] ? bound_top[BYTE_W-1:0] : sgn ? bound_bot[BYTE_W-1:0] : '0;
		end
		for (int h = 0; h < HALVES_PER_WORD; h++) begin
			res16[h*HALF_W +: HALF_W] = keep[OV_HALF_LSB+h] ? opnd.rs1[h*HALF_W +: HALF_W] :
				!neg[OV_HALF_LSB+h] ? bound_top[HALF_W-1:0] :
				sgn ? bound_bot[HALF_W-1:0] : '0;
		end
		res32 = keep[OV_WORD_BIT] ? opnd.rs1 :
			!neg[OV_WORD_BIT] ? bound_top : sgn ? bound_bot : '0;
	end

	always_comb begin
		wdat_o = '0;
		ov_o = 1'b0;
		if (clip32) begin
			wdat_o = res32;
			ov_o = !keep[OV_WORD_BIT];
		end else if (clip16) begin
			wdat_o = res16;
			ov_o = !(&keep[OV_WORD_BIT-1:OV_HALF_LSB]);
		end else if (clip8) begin
			wdat_o = res8;
			ov_o = !(&keep[OV_HALF_LSB-1:0]);
		end
	end

	// word form against a plain signed compare.
	a_ov_word_bounds: assert property (@(posedge clk) disable iff (reset_i)
		clip32 |-> ov_o == ($signed(opnd.rs1) > $signed(bound_top) ||
		$signed(opnd.rs1) < $signed(sgn ? bound_bot : XLEN'(0))));

endmodule

/* source/dsp_count_unit.sv */
`timescale 1ns/1ns

module dsp_count_unit (
	dsp_operand_if.unit                   opnd,
	output logic [dsp_misc_pkg::XLEN-1:0] wdat_o
);
	import dsp_misc_pkg::*;

	localparam int CNT32_W = $clog2(XLEN + 1);
	localparam int CNT16_W = $clog2(HALF_W + 1);
	localparam int CNT8_W = $clog2(BYTE_W + 1);

	logic cl8;
	logic cl16;
	logic cl32;
	logic clz;
	logic clrs;
	logic [XLEN-1:0] word_prep;
	logic [HALF_W-1:0] half_prep;
	logic [CNT32_W-1:0] cnt32;
	logic [CNT16_W-1:0] cnt16;
	logic [CNT8_W-1:0] cnt8 [2];

	assign cl8 = opnd.info[INFO_CLRS8] | opnd.info[INFO_CLZ8] | opnd.info[INFO_CLO8];
	assign cl16 = opnd.info[INFO_CLRS16] | opnd.info[INFO_CLZ16] | opnd.info[INFO_CLO16];
	assign cl32 = opnd.info[INFO_CLRS32] | opnd.info[INFO_CLZ32] | opnd.info[INFO_CLO32];
	assign clz = opnd.info[INFO_CLZ8] | opnd.info[INFO_CLZ16] | opnd.info[INFO_CLZ32];
	assign clrs = opnd.info[INFO_CLRS8] | opnd.info[INFO_CLRS16] | opnd.info[INFO_CLRS32];

	// stop bit just below the lane edge.
	always_comb begin
		word_prep = opnd.rs1;
		half_prep = opnd.rs1[HALF_W-1:0];
		if (cl8) begin
			word_prep[XLEN-BYTE_W-1] = clz | (clrs & ~opnd.rs1[XLEN-1]);
			half_prep[BYTE_W-1] = clz | (clrs & ~opnd.rs1[HALF_W-1]);
		end
		if (cl16) begin
			word_prep[HALF_W-1] = clz | (clrs & ~opnd.rs1[XLEN-1]);
		end
	end

	dsp_lead_count #(.WIDTH(XLEN)) u_word_cnt (
		.lane_i    (clrs ? {word_prep[XLEN-2:0], ~word_prep[XLEN-1]} : word_prep),
		.cmp_bit_i (clz ? 1'b0 : clrs ? opnd.rs1[XLEN-1] : 1'b1),
		.cnt_o     (cnt32)
	);

	dsp_lead_count #(.WIDTH(HALF_W)) u_half_cnt (
		.lane_i    (clrs ? {half_prep[HALF_W-2:0], ~half_prep[HALF_W-1]} : half_prep),
		.cmp_bit_i (clz ? 1'b0 : clrs ? opnd.rs1[HALF_W-1] : 1'b1),
		.cnt_o     (cnt16)
	);

	// bytes 0 and 2; bytes 1 and 3 come from the wider cells.
	for (genvar g = 0; g < 2; g++) begin : g_byte
		logic [BYTE_W-1:0] lane;

		assign lane = opnd.rs1[2*g*BYTE_W +: BYTE_W];

		dsp_lead_count #(.WIDTH(BYTE_W)) u_byte_cnt (
			.lane_i    (clrs ? {lane[BYTE_W-2:0], ~lane[BYTE_W-1]} : lane),
			.cmp_bit_i (clz ? 1'b0 : clrs ? lane[BYTE_W-1] : 1'b1),
			.cnt_o     (cnt8[g])
		);
	end

	always_comb begin
		wdat_o = '0;
		if (cl8) begin
			wdat_o = {BYTE_W'(cnt32), BYTE_W'(cnt8[1]), BYTE_W'(cnt16), BYTE_W'(cnt8[0])};
		end else if (cl16) begin
			wdat_o = {HALF_W'(cnt32), HALF_W'(cnt16)};
		end else if (cl32) begin
			wdat_o = XLEN'(cnt32);
		end
	end

endmodule

/* source/dsp_lead_count.sv */
`timescale 1ns/1ns

module dsp_lead_count #(
	parameter int WIDTH = 32,
	localparam int CNT_W = $clog2(WIDTH + 1)
) (
	input  logic [WIDTH-1:0] lane_i,
	input  logic             cmp_bit_i,
	output logic [CNT_W-1:0] cnt_o
);
	logic [WIDTH-1:0] diff;
	logic [WIDTH:0] seen; // a differing bit at or above i.
	logic [WIDTH-1:0] first;

	assign diff = lane_i ^ {WIDTH{cmp_bit_i}};

	always_comb begin
		seen[WIDTH] = 1'b0;
		for (int i = WIDTH - 1; i >= 0; i--) begin
			seen[i] = seen[i+1] | diff[i];
		end
	end

	assign first = seen[WIDTH-1:0] & ~seen[WIDTH:1];

	// whole lane matched when nothing differs.
	always_comb begin
		cnt_o = seen[0] ? '0 : CNT_W'(WIDTH);
		for (int i = 0; i < WIDTH; i++) begin
			if (first[i]) begin
				cnt_o = cnt_o | CNT_W'(WIDTH - 1 - i);
			end
		end
	end

	// top cnt_o bits match, the bit below them differs.
	always_comb begin
		a_cnt_match: assert (cnt_o == CNT_W'(WIDTH) ? diff == '0 :
			(diff >> (WIDTH - 1 - int'(cnt_o))) == WIDTH'(1))
			else $error("lead count does not match the lane");
	end

endmodule

/* source/dsp_misc_pkg.sv */
package dsp_misc_pkg;

	localparam int XLEN = 32;

	// one-hot operation flags, immediate above them.
	localparam int INFO_SCLIP8 = 0;
	localparam int INFO_UCLIP8 = 1;
	localparam int INFO_SCLIP16 = 2;
	localparam int INFO_UCLIP16 = 3;
	localparam int INFO_SCLIP32 = 4;
	localparam int INFO_UCLIP32 = 5;
	localparam int INFO_SUNPKD810 = 6;
	localparam int INFO_SUNPKD820 = 7;
	localparam int INFO_SUNPKD830 = 8;
	localparam int INFO_SUNPKD831 = 9;
	localparam int INFO_SUNPKD832 = 10;
	localparam int INFO_ZUNPKD810 = 11;
	localparam int INFO_ZUNPKD820 = 12;
	localparam int INFO_ZUNPKD830 = 13;
	localparam int INFO_ZUNPKD831 = 14;
	localparam int INFO_ZUNPKD832 = 15;
	localparam int INFO_PKBB16 = 16;
	localparam int INFO_PKBT16 = 17;
	localparam int INFO_PKTB16 = 18;
	localparam int INFO_PKTT16 = 19;
	localparam int INFO_CLRS8 = 20;
	localparam int INFO_CLZ8 = 21;
	localparam int INFO_CLO8 = 22;
	localparam int INFO_CLRS16 = 23;
	localparam int INFO_CLZ16 = 24;
	localparam int INFO_CLO16 = 25;
	localparam int INFO_CLRS32 = 26;
	localparam int INFO_CLZ32 = 27;
	localparam int INFO_CLO32 = 28;
	localparam int INFO_BPICK = 29;
	localparam int INFO_INSB = 30;
	localparam int INFO_SWAP8 = 31;
	localparam int INFO_SWAP16 = 32;

	localparam int OP_W = 33; // number of operation flags.
	localparam int IMM_W = 5;
	localparam int INFO_IMM_LSB = OP_W;
	localparam int INFO_W = INFO_IMM_LSB + IMM_W;

	localparam int BYTE_W = 8;
	localparam int HALF_W = 16;
	localparam int BYTES_PER_WORD = 4;
	localparam int HALVES_PER_WORD = 2;

	// lane flag vector: bytes, then halves, then the word.
	localparam int OV_HALF_LSB = BYTES_PER_WORD;
	localparam int OV_WORD_BIT = BYTES_PER_WORD + HALVES_PER_WORD;
	localparam int OV_W = OV_WORD_BIT + 1;

endpackage

/* source/dsp_misc_top.sv */
`timescale 1ns/1ns

module dsp_misc_top (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic [dsp_misc_pkg::XLEN-1:0]   rs1_i,
	input  logic [dsp_misc_pkg::XLEN-1:0]   rs2_i,
	input  logic [dsp_misc_pkg::XLEN-1:0]   rc_i,
	input  logic [dsp_misc_pkg::XLEN-1:0]   rd_i,
	input  logic [dsp_misc_pkg::INFO_W-1:0] info_i,
	output logic [dsp_misc_pkg::XLEN-1:0]   wdat_o,
	output logic                            ov_o
);
	import dsp_misc_pkg::*;

	logic [XLEN-1:0] clip_wdat;
	logic [XLEN-1:0] cnt_wdat;
	logic [XLEN-1:0] perm_wdat;

	dsp_operand_if opnd ();

	assign opnd.rs1 = rs1_i;
	assign opnd.rs2 = rs2_i;
	assign opnd.rc = rc_i;
	assign opnd.rd = rd_i;
	assign opnd.info = info_i;

	dsp_clip_unit u_clip (
		.clk     (clk),
		.reset_i (reset_i),
		.opnd    (opnd),
		.wdat_o  (clip_wdat),
		.ov_o    (ov_o)
	);

	dsp_count_unit u_count (.opnd(opnd), .wdat_o(cnt_wdat));

	dsp_permute_unit u_permute (.opnd(opnd), .wdat_o(perm_wdat));

	assign wdat_o = clip_wdat | cnt_wdat | perm_wdat; // idle units give zero.

	a_info_onehot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0(info_i[OP_W-1:0]));

endmodule

/* source/dsp_operand_if.sv */
`timescale 1ns/1ns

interface dsp_operand_if;
	import dsp_misc_pkg::*;

	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic [XLEN-1:0] rc; // bpick mask.
	logic [XLEN-1:0] rd; // insb destination.
	logic [INFO_W-1:0] info;

	modport unit (
		input rs1,
		input rs2,
		input rc,
		input rd,
		input info
	);

endinterface

/* source/dsp_permute_unit.sv */
`timescale 1ns/1ns

module dsp_permute_unit (
	dsp_operand_if.unit                   opnd,
	output logic [dsp_misc_pkg::XLEN-1:0] wdat_o
);
	import dsp_misc_pkg::*;

	logic sext;
	logic [1:0] ins_pos;
	logic [HALF_W-1:0] ext_byte [BYTES_PER_WORD];
	logic [XLEN-1:0] rs1;
	logic [XLEN-1:0] rs2;
	logic [XLEN-1:0] unpk;
	logic [XLEN-1:0] pack;
	logic [XLEN-1:0] swap;
	logic [XLEN-1:0] ins_mask;
	logic [XLEN-1:0] ins;
	logic [XLEN-1:0] pick;

	assign rs1 = opnd.rs1;
	assign rs2 = opnd.rs2;
	assign ins_pos = opnd.info[INFO_IMM_LSB +: 2];
	assign sext = opnd.info[INFO_SUNPKD810] | opnd.info[INFO_SUNPKD820] |
		opnd.info[INFO_SUNPKD830] | opnd.info[INFO_SUNPKD831] | opnd.info[INFO_SUNPKD832];

	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			ext_byte[b] = {{BYTE_W{sext & rs1[b*BYTE_W+BYTE_W-1]}}, rs1[b*BYTE_W +: BYTE_W]};
			ins_mask[b*BYTE_W +: BYTE_W] = {BYTE_W{ins_pos == 2'(b)}};
		end
	end

	// first digit picks the upper halfword.
	assign unpk =
		({XLEN{opnd.info[INFO_SUNPKD810] | opnd.info[INFO_ZUNPKD810]}} & {ext_byte[1], ext_byte[0]}) |
		({XLEN{opnd.info[INFO_SUNPKD820] | opnd.info[INFO_ZUNPKD820]}} & {ext_byte[2], ext_byte[0]}) |
		({XLEN{opnd.info[INFO_SUNPKD830] | opnd.info[INFO_ZUNPKD830]}} & {ext_byte[3], ext_byte[0]}) |
		({XLEN{opnd.info[INFO_SUNPKD831] | opnd.info[INFO_ZUNPKD831]}} & {ext_byte[3], ext_byte[1]}) |
		({XLEN{opnd.info[INFO_SUNPKD832] | opnd.info[INFO_ZUNPKD832]}} & {ext_byte[3], ext_byte[2]});

	assign pack =
		({XLEN{opnd.info[INFO_PKBB16]}} & {rs1[HALF_W-1:0], rs2[HALF_W-1:0]}) |
		({XLEN{opnd.info[INFO_PKBT16]}} & {rs1[HALF_W-1:0], rs2[XLEN-1:HALF_W]}) |
		({XLEN{opnd.info[INFO_PKTB16]}} & {rs1[XLEN-1:HALF_W], rs2[HALF_W-1:0]}) |
		({XLEN{opnd.info[INFO_PKTT16]}} & {rs1[XLEN-1:HALF_W], rs2[XLEN-1:HALF_W]});

	assign swap =
		({XLEN{opnd.info[INFO_SWAP8]}} & {rs1[23:16], rs1[31:24], rs1[7:0], rs1[15:8]}) |
		({XLEN{opnd.info[INFO_SWAP16]}} & {rs1[HALF_W-1:0], rs1[XLEN-1:HALF_W]});

	assign ins = {XLEN{opnd.info[INFO_INSB]}} &
		((ins_mask & {BYTES_PER_WORD{rs1[BYTE_W-1:0]}}) | (~ins_mask & opnd.rd));

	assign pick = {XLEN{opnd.info[INFO_BPICK]}} & ((opnd.rc & rs1) | (~opnd.rc & rs2));

	assign wdat_o = unpk | pack | swap | ins | pick;

endmodule

/* source/dsp_sat_detect.sv */
`timescale 1ns/1ns

module dsp_sat_detect (
	input  logic [dsp_misc_pkg::XLEN-1:0] op_i,
	input  logic [dsp_misc_pkg::XLEN-1:0] bound_top_i,
	input  logic [dsp_misc_pkg::XLEN-1:0] bound_bot_i,
	output logic [dsp_misc_pkg::OV_W-1:0] t_ov_o,
	output logic [dsp_misc_pkg::OV_W-1:0] b_ov_o
);
	import dsp_misc_pkg::*;

	// negative lanes compare like unsigned against a negative bound.
	always_comb begin
		for (int b = 0; b < BYTES_PER_WORD; b++) begin
			t_ov_o[b] = !op_i[b*BYTE_W+BYTE_W-1] &&
				(op_i[b*BYTE_W +: BYTE_W] > bound_top_i[BYTE_W-1:0]);
			b_ov_o[b] = op_i[b*BYTE_W+BYTE_W-1] &&
				(op_i[b*BYTE_W +: BYTE_W] < bound_bot_i[BYTE_W-1:0]);
		end
		for (int h = 0; h < HALVES_PER_WORD; h++) begin
			t_ov_o[OV_HALF_LSB+h] = !op_i[h*HALF_W+HALF_W-1] &&
				(op_i[h*HALF_W +: HALF_W] > bound_top_i[HALF_W-1:0]);
			b_ov_o[OV_HALF_LSB+h] = op_i[h*HALF_W+HALF_W-1] &&
				(op_i[h*HALF_W +: HALF_W] < bound_bot_i[HALF_W-1:0]);
		end
		t_ov_o[OV_WORD_BIT] = !op_i[XLEN-1] && (op_i > bound_top_i);
		b_ov_o[OV_WORD_BIT] = op_i[XLEN-1] && (op_i < bound_bot_i);
	end

endmodule
